//--- include/spike_gen_settings.svh
`ifndef SPIKE_GEN_SETTINGS_SVH
`define SPIKE_GEN_SETTINGS_SVH

// number of generator slices in the array
`define SG_NGENS 8

// period and countdown width
`define SG_NPERIOD 16

// output tag and spike count widths
`define SG_NTAG 11
`define SG_NCT 10

// generator index width, log2 of SG_NGENS
`define SG_IDXW 3

`endif

//--- source/spike_gen_pkg.sv
`include "spike_gen_settings.svh"

package spike_gen_pkg;

  // one program word, also the decoder to slice write bus
  typedef struct packed {
    logic [`SG_IDXW-1:0]    gen_idx;
    logic [`SG_NPERIOD-1:0] period;
    logic [`SG_NPERIOD-1:0] ticks;
    logic [`SG_NTAG-1:0]    tag;
  } prog_word_t;

  // one output word, tag plus merged spike count
  typedef struct packed {
    logic [`SG_NTAG-1:0] tag;
    logic [`SG_NCT-1:0]  ct;
  } spike_word_t;

  // static array configuration
  // gens_used is one bit wider than an index so it can hold SG_NGENS
  typedef struct packed {
    logic [`SG_IDXW:0]     gens_used;
    logic [`SG_NGENS-1:0]  gens_en;
  } gen_conf_t;

  // valid/ack handshake state
  typedef enum logic {
    hs_idle,
    hs_hold
  } hs_state_e;

endpackage

//--- source/spike_prog_decoder.sv
`timescale 1ns/100ps
`include "spike_gen_settings.svh"

module spike_prog_decoder import spike_gen_pkg::*; (
  input  logic                 clk,
  input  logic                 arst_n,
  input  logic                 prog_valid,
  input  prog_word_t           prog_word,
  output logic                 prog_ack,
  output logic [`SG_NGENS-1:0] wr_en,
  output prog_word_t           wr_word
);

  hs_state_e            state_q;
  logic                 accept;
  logic [`SG_NGENS-1:0] wr_dec;

  // a word is taken only from idle, hold blocks a lingering valid
  assign accept = (state_q == hs_idle) && prog_valid;

  always_comb begin
    wr_dec = '0;
    wr_dec[prog_word.gen_idx] = 1'b1;
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      state_q  <= hs_idle;
      prog_ack <= 1'b0;
      wr_en    <= '0;
    end else begin
      prog_ack <= 1'b0;
      wr_en    <= '0;
      case (state_q)
        hs_idle: begin
          if (prog_valid) begin
            prog_ack <= 1'b1;
            wr_en    <= wr_dec;
            state_q  <= hs_hold;
          end
        end
        // wait for the driver to drop valid after ack
        hs_hold: begin
          if (!prog_valid) begin
            state_q <= hs_idle;
          end
        end
        default: state_q <= hs_idle;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (accept) begin
      wr_word <= prog_word;
    end
  end

  a_ack_single: assert property (@(posedge clk) disable iff (!arst_n)
    prog_ack |=> !prog_ack);

  a_idx_range: assert property (@(posedge clk) disable iff (!arst_n)
    prog_valid |-> (prog_word.gen_idx < `SG_NGENS));

endmodule

//--- source/spike_gen_slice.sv
`timescale 1ns/100ps
`include "spike_gen_settings.svh"

module spike_gen_slice import spike_gen_pkg::*; (
  input  logic                clk,
  input  logic                arst_n,
  input  logic                active,
  input  logic                unit_pulse,
  input  logic                wr_en,
  input  prog_word_t          wr_word,
  input  logic                take,
  input  logic [`SG_NCT-1:0]  take_ct,
  output logic                pending,
  output logic [`SG_NTAG-1:0] tag,
  output logic [`SG_NCT-1:0]  ct
);

  logic [`SG_NPERIOD-1:0] period_q;
  logic [`SG_NPERIOD-1:0] countdown_q;
  logic [`SG_NTAG-1:0]    tag_q;
  logic [`SG_NCT-1:0]     ct_q;

  logic                   tick;
  logic                   spike;
  logic [`SG_NCT-1:0]     ct_base;
  logic [`SG_NCT:0]       ct_sum;
  logic [`SG_NCT-1:0]     ct_next;

  // only an active slice sees the unit pulse
  assign tick  = active && unit_pulse;
  assign spike = tick && (countdown_q == '0);

  // drained amount leaves while a same-cycle spike still lands
  assign ct_base = take ? (ct_q - take_ct) : ct_q;
  assign ct_sum  = {1'b0, ct_base} + {{`SG_NCT{1'b0}}, spike};

  // saturate at all ones
  always_comb begin
    if (ct_sum[`SG_NCT]) begin
      ct_next = '1;
    end else begin
      ct_next = ct_sum[`SG_NCT-1:0];
    end
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      period_q    <= '0;
      countdown_q <= '0;
      tag_q       <= '0;
    end else if (wr_en) begin
      period_q    <= wr_word.period;
      countdown_q <= wr_word.ticks;
      tag_q       <= wr_word.tag;
    end else if (tick) begin
      if (countdown_q == '0) begin
        countdown_q <= period_q;
      end else begin
        countdown_q <= countdown_q - 1'b1;
      end
    end
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      ct_q <= '0;
    end else if (wr_en) begin
      // reprogramming discards whatever was pending
      ct_q <= '0;
    end else begin
      ct_q <= ct_next;
    end
  end

  assign pending = (ct_q != '0);
  assign tag     = tag_q;
  assign ct      = ct_q;

  // the arbiter must never take more than the slice holds
  a_take_le_ct: assert property (@(posedge clk) disable iff (!arst_n)
    take |-> (take_ct <= ct_q));

endmodule

//--- source/spike_out_arbiter.sv
`timescale 1ns/100ps
`include "spike_gen_settings.svh"

module spike_out_arbiter import spike_gen_pkg::*; (
  input  logic                                 clk,
  input  logic                                 arst_n,
  input  logic [`SG_NGENS-1:0]                 pending,
  input  logic [`SG_NGENS-1:0][`SG_NTAG-1:0]   gen_tag,
  input  logic [`SG_NGENS-1:0][`SG_NCT-1:0]    gen_ct,
  output logic [`SG_NGENS-1:0]                 take,
  output logic [`SG_NCT-1:0]                   take_ct,
  output logic                                 out_valid,
  output spike_word_t                          out_word,
  input  logic                                 out_ack
);

  hs_state_e            state_q;
  logic [`SG_IDXW-1:0]  last_q;
  logic [`SG_IDXW-1:0]  sel;
  logic                 found;
  logic                 capture;

  // round-robin search, starting one past the last slice served
  always_comb begin
    int unsigned idx;
    found = 1'b0;
    sel   = last_q;
    for (int i = 1; i <= `SG_NGENS; i++) begin
      idx = (int'(last_q) + i) % `SG_NGENS;
      if (!found && pending[idx]) begin
        found = 1'b1;
        sel   = idx[`SG_IDXW-1:0];
      end
    end
  end

  assign capture = (state_q == hs_idle) && found;

  // take goes out in the capture cycle so the slice drains on the same edge
  always_comb begin
    take = '0;
    if (capture) begin
      take[sel] = 1'b1;
    end
  end

  assign take_ct = gen_ct[sel];

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      state_q <= hs_idle;
      last_q  <= `SG_IDXW'(`SG_NGENS - 1);
    end else begin
      case (state_q)
        hs_idle: begin
          if (capture) begin
            state_q <= hs_hold;
            last_q  <= sel;
          end
        end
        hs_hold: begin
          if (out_ack) begin
            state_q <= hs_idle;
          end
        end
        default: state_q <= hs_idle;
      endcase
    end
  end

  // output word only changes on capture
  always_ff @(posedge clk) begin
    if (capture) begin
      out_word.tag <= gen_tag[sel];
      out_word.ct  <= gen_ct[sel];
    end
  end

  assign out_valid = (state_q == hs_hold);

  a_out_stable: assert property (@(posedge clk) disable iff (!arst_n)
    (out_valid && !out_ack) |=> (out_valid && $stable(out_word)));

  a_take_onehot: assert property (@(posedge clk) disable iff (!arst_n)
    $onehot0(take));

endmodule

//--- source/spike_gen_array.sv
`timescale 1ns/100ps
`include "spike_gen_settings.svh"

module spike_gen_array import spike_gen_pkg::*; (
  input  logic        clk,
  input  logic        arst_n,
  input  logic        unit_pulse,
  input  gen_conf_t   conf,
  input  logic        prog_valid,
  input  prog_word_t  prog_word,
  output logic        prog_ack,
  output logic        out_valid,
  output spike_word_t out_word,
  input  logic        out_ack
);

  logic [`SG_NGENS-1:0]               wr_en;
  prog_word_t                         wr_word;
  logic [`SG_NGENS-1:0]               active;

  logic [`SG_NGENS-1:0]               pending;
  logic [`SG_NGENS-1:0][`SG_NTAG-1:0] gen_tag;
  logic [`SG_NGENS-1:0][`SG_NCT-1:0]  gen_ct;
  logic [`SG_NGENS-1:0]               take;
  logic [`SG_NCT-1:0]                 take_ct;

  spike_prog_decoder u_decoder (
    .clk        (clk),
    .arst_n     (arst_n),
    .prog_valid (prog_valid),
    .prog_word  (prog_word),
    .prog_ack   (prog_ack),
    .wr_en      (wr_en),
    .wr_word    (wr_word)
  );

  for (genvar g = 0; g < `SG_NGENS; g++) begin : g_slice

    // in use and enabled
    assign active[g] = (g < conf.gens_used) && conf.gens_en[g];

    spike_gen_slice u_slice (
      .clk        (clk),
      .arst_n     (arst_n),
      .active     (active[g]),
      .unit_pulse (unit_pulse),
      .wr_en      (wr_en[g]),
      .wr_word    (wr_word),
      .take       (take[g]),
      .take_ct    (take_ct),
      .pending    (pending[g]),
      .tag        (gen_tag[g]),
      .ct         (gen_ct[g])
    );

  end

  spike_out_arbiter u_arbiter (
    .clk        (clk),
    .arst_n     (arst_n),
    .pending    (pending),
    .gen_tag    (gen_tag),
    .gen_ct     (gen_ct),
    .take       (take),
    .take_ct    (take_ct),
    .out_valid  (out_valid),
    .out_word   (out_word),
    .out_ack    (out_ack)
  );

endmodule

//--- dv/spike_gen_array_tb.sv
`timescale 1ns/100ps
`include "spike_gen_settings.svh"

module spike_gen_array_tb import spike_gen_pkg::*; ();

  logic        clk;
  logic        arst_n;
  logic        unit_pulse;
  gen_conf_t   conf;
  logic        prog_valid;
  prog_word_t  prog_word;
  logic        prog_ack;
  logic        out_valid;
  spike_word_t out_word;
  logic        out_ack;

  // reference model state per generator
  int          m_period [`SG_NGENS];
  int          m_cd [`SG_NGENS];
  int          m_tag [`SG_NGENS];
  bit          m_prog [`SG_NGENS];
  int          exp_total [`SG_NGENS];
  int          outstanding [`SG_NGENS];
  int          got_total [`SG_NGENS];

  bit          pulses_on;
  bit          hold_ack;
  bit          gen0_off;
  bit          held;
  spike_word_t held_word;
  int          hold_cycles;
  int          ack_count;
  int          words_sent;
  int          mon_gen;
  int          snap_513;
  logic [31:0] rng;

  spike_gen_array dut0 (
    .clk        (clk),
    .arst_n     (arst_n),
    .unit_pulse (unit_pulse),
    .conf       (conf),
    .prog_valid (prog_valid),
    .prog_word  (prog_word),
    .prog_ack   (prog_ack),
    .out_valid  (out_valid),
    .out_word   (out_word),
    .out_ack    (out_ack)
  );

  initial begin
    clk = 1'b0;
    forever begin
      #5 clk = ~clk;
    end
  end

  task automatic fail_now(input string msg);
    $display("%s", msg);
    $display("STATUS: FAIL");
    $fatal(1);
  endtask

  function automatic logic [31:0] xorshift(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  // returns 1 when this unit pulse gives a spike
  function automatic bit model_pulse(input int g);
    bit spike;
    spike = 1'b0;
    if ((g < conf.gens_used) && conf.gens_en[g]) begin
      if (m_cd[g] == 0) begin
        spike   = 1'b1;
        m_cd[g] = m_period[g];
      end else begin
        m_cd[g] = m_cd[g] - 1;
      end
    end
    return spike;
  endfunction

  function automatic int find_gen(input logic [`SG_NTAG-1:0] tag);
    int found;
    found = -1;
    for (int g = 0; g < `SG_NGENS; g++) begin
      if (m_prog[g] && (m_tag[g] == tag)) begin
        found = g;
      end
    end
    return found;
  endfunction

  task automatic check_ack(input logic got, input logic exp, input string name);
    if (got !== exp) begin
      fail_now($sformatf("error %s: got %h expected %h", name, got, exp));
    end
  endtask

  task automatic check_spike(input spike_word_t w);
    int g;
    g = find_gen(w.tag);
    if (g < 0) begin
      fail_now($sformatf("error out_word.tag: got %h, not a programmed tag", w.tag));
    end
    if (g >= conf.gens_used) begin
      fail_now($sformatf("generator %0d sent a word although it is beyond gens_used", g));
    end
    if (gen0_off && (g == 0)) begin
      fail_now("generator 0 sent a word after it was disabled and drained");
    end
    if ((w.ct == 0) || (w.ct > outstanding[g])) begin
      fail_now($sformatf("error out_word.ct: got %h expected 1 to %h", w.ct, outstanding[g]));
    end
  endtask

  task automatic check_hold(input spike_word_t got, input spike_word_t exp, input logic valid);
    if (valid !== 1'b1) begin
      fail_now("out_valid dropped before the word was acknowledged");
    end
    if (got !== exp) begin
      fail_now($sformatf("error out_word: got %h expected %h", got, exp));
    end
  endtask

  task automatic check_total(input string name, input int got, input int exp);
    if (got != exp) begin
      fail_now($sformatf("error %s: got %h expected %h", name, got, exp));
    end
  endtask

  // unit pulse every 32 cycles with the model stepped on each one
  initial begin : pulse_gen
    int phase;
    unit_pulse = 1'b0;
    phase = 0;
    forever begin
      @(posedge clk);
      #1;
      unit_pulse = 1'b0;
      if (pulses_on) begin
        phase = (phase + 1) % 32;
        if (phase == 0) begin
          unit_pulse = 1'b1;
          for (int g = 0; g < `SG_NGENS; g++) begin
            if (model_pulse(g)) begin
              exp_total[g]++;
              outstanding[g]++;
            end
          end
        end
      end
    end
  end

  initial begin : ack_gen
    out_ack = 1'b0;
    rng = 32'd38420;
    forever begin
      @(posedge clk);
      #1;
      rng = xorshift(rng);
      out_ack = hold_ack ? 1'b0 : rng[3];
    end
  end

  // transfer monitor
  always @(posedge clk) begin
    if (arst_n) begin
      if (prog_ack) begin
        ack_count++;
      end
      if (held) begin
        check_hold(out_word, held_word, out_valid);
        if (hold_ack) begin
          hold_cycles++;
        end
      end
      if (out_valid && out_ack) begin
        check_spike(out_word);
        mon_gen = find_gen(out_word.tag);
        outstanding[mon_gen] -= out_word.ct;
        got_total[mon_gen] += out_word.ct;
      end
      held      = out_valid && !out_ack;
      held_word = out_word;
    end
  end

  task automatic program_gen(input int g, input int period, input int ticks, input int tag);
    prog_word_t w;
    int n;
    w.gen_idx = `SG_IDXW'(g);
    w.period  = `SG_NPERIOD'(period);
    w.ticks   = `SG_NPERIOD'(ticks);
    w.tag     = `SG_NTAG'(tag);
    m_period[g] = period;
    m_cd[g]     = ticks;
    m_tag[g]    = tag;
    m_prog[g]   = 1'b1;
    @(posedge clk);
    #1;
    prog_valid = 1'b1;
    prog_word  = w;
    words_sent++;
    n = 0;
    // ack expected on the second edge one cycle after valid is sampled
    do begin
      @(posedge clk);
      n++;
      check_ack(prog_ack, n == 2, "prog_ack");
    end while (!prog_ack && (n < 8));
    if (!prog_ack) begin
      fail_now("timeout waiting for prog_ack");
    end
    #1;
    prog_valid = 1'b0;
    @(posedge clk);
    check_ack(prog_ack, 1'b0, "prog_ack");
  endtask

  task automatic drain_output(input int limit);
    int n;
    int quiet;
    n = 0;
    quiet = 0;
    // drained once the arbiter has stayed idle for a few cycles
    do begin
      @(negedge clk);
      n++;
      if (out_valid) begin
        quiet = 0;
      end else begin
        quiet++;
      end
    end while ((quiet < 4) && (n < limit));
    if (quiet < 4) begin
      fail_now("timeout waiting for the output to drain");
    end
  endtask

  task automatic check_totals();
    for (int g = 0; g < `SG_NGENS; g++) begin
      check_total($sformatf("ct total of generator %0d", g), got_total[g], exp_total[g]);
    end
  endtask

  initial begin
    arst_n     = 1'b0;
    conf       = '0;
    prog_valid = 1'b0;
    prog_word  = '0;
    pulses_on  = 1'b0;
    hold_ack   = 1'b0;
    gen0_off   = 1'b0;
    held       = 1'b0;
    repeat (4) @(posedge clk);
    #1;
    arst_n = 1'b1;
    @(posedge clk);
    check_ack(prog_ack, 1'b0, "prog_ack");
    check_ack(out_valid, 1'b0, "out_valid");

    program_gen(0, 2, 0, 512);
    program_gen(1, 4, 2, 513);
    // programmed but outside gens_used
    program_gen(5, 1, 0, 517);
    @(posedge clk);
    #1;
    conf.gens_used = 2;
    conf.gens_en   = 8'h23;

    @(negedge clk);
    pulses_on = 1'b1;
    repeat (40 * 32) @(posedge clk);

    // back-pressure stretch while pulses keep coming
    @(negedge clk);
    hold_ack = 1'b1;
    repeat (150) @(posedge clk);
    @(negedge clk);
    hold_ack = 1'b0;
    if (hold_cycles == 0) begin
      fail_now("no word was held during the back-pressure stretch");
    end
    repeat (20 * 32) @(posedge clk);

    @(negedge clk);
    pulses_on = 1'b0;
    drain_output(2000);
    check_totals();

    // drop generator 0 while tag 513 keeps flowing
    snap_513 = got_total[1];
    @(posedge clk);
    #1;
    conf.gens_en[0] = 1'b0;
    gen0_off = 1'b1;
    @(negedge clk);
    pulses_on = 1'b1;
    repeat (30 * 32) @(posedge clk);
    @(negedge clk);
    pulses_on = 1'b0;
    drain_output(2000);
    check_totals();
    if (got_total[1] <= snap_513) begin
      fail_now("tag 513 stopped after generator 0 was disabled");
    end
    check_total("prog_ack count", ack_count, words_sent);

    $display("STATUS: PASS");
    $finish;
  end

endmodule

//--- src.f
+incdir+include
source/spike_gen_pkg.sv
source/spike_prog_decoder.sv
source/spike_gen_slice.sv
source/spike_out_arbiter.sv
source/spike_gen_array.sv
dv/spike_gen_array_tb.sv
